// ==== include/clint_consts.svh ====
`ifndef CLINT_CONSTS_SVH
`define CLINT_CONSTS_SVH

// data path width
`define XLEN                64

// clint address window
`define CLINT_BASE          64'h0000_0000_0200_0000
`define CLINT_SPAN          64'h0000_0000_0001_0000
`define CLINT_OFF_W         16

// register offsets inside the window
`define CLINT_MTIMECMP_OFF  16'h4000
`define CLINT_MTIME_OFF     16'hBFF8

// clock cycles per mtime increment
`define CLINT_TICK_DIV      4

// handshake response codes
`define RESP_OKAY           2'd0
`define RESP_SLVERR         2'd2

// log2 of access bytes for a doubleword
`define SIZE_DOUBLE         2'd3

`endif

// ==== design/clint_pkg.sv ====
`include "clint_consts.svh"

package clint_pkg;

    // byte address on every request port
    typedef logic [`XLEN-1:0] addr_t;

    // one data word, read or write
    typedef logic [`XLEN-1:0] data_t;

    // log2 of access bytes
    typedef logic [1:0]       size_t;

    // okay / slverr
    typedef logic [1:0]       resp_t;

endpackage

// ==== design/mem_dstb.sv ====
`timescale 1ns/100ps
`include "clint_consts.svh"

module mem_dstb (
    // master side
    input  logic                    mem_valid,
    input  clint_pkg::addr_t        mem_addr,
    input  clint_pkg::size_t        mem_size,
    input  logic                    mem_req,
    input  clint_pkg::data_t        mem_data_write,
    output logic                    mem_ready,
    output clint_pkg::data_t        mem_data_read,
    output clint_pkg::resp_t        mem_resp,

    // external memory side
    output logic                    cpu_mem_valid,
    output clint_pkg::addr_t        cpu_mem_addr,
    output clint_pkg::size_t        cpu_mem_size,
    output logic                    cpu_mem_req,
    output clint_pkg::data_t        cpu_mem_data_write,
    input  logic                    cpu_mem_ready,
    input  clint_pkg::data_t        cpu_mem_data_read,
    input  clint_pkg::resp_t        cpu_mem_resp,

    // clint side
    output logic                    clint_valid,
    output logic [`CLINT_OFF_W-1:0] clint_addr,
    output clint_pkg::size_t        clint_size,
    output logic                    clint_req,
    output clint_pkg::data_t        clint_data_write,
    input  logic                    clint_ready,
    input  clint_pkg::data_t        clint_data_read,
    input  clint_pkg::resp_t        clint_resp
);
    import clint_pkg::*;

    addr_t win_off;
    logic  sel_clint;

    // offset from window base, wraps below base so one compare covers both ends
    assign win_off   = mem_addr - `CLINT_BASE;
    assign sel_clint = (win_off < `CLINT_SPAN);

    // valid goes to exactly one target
    assign cpu_mem_valid = mem_valid & ~sel_clint;
    assign clint_valid   = mem_valid & sel_clint;

    // request fields fan out to both
    assign cpu_mem_addr       = mem_addr;
    assign cpu_mem_size       = mem_size;
    assign cpu_mem_req        = mem_req;
    assign cpu_mem_data_write = mem_data_write;

    assign clint_addr       = win_off[`CLINT_OFF_W-1:0];
    assign clint_size       = mem_size;
    assign clint_req        = mem_req;
    assign clint_data_write = mem_data_write;

    // response back from the selected target
    always_comb begin
        if (sel_clint) begin
            mem_ready     = clint_ready;
            mem_data_read = clint_data_read;
            mem_resp      = clint_resp;
        end else begin
            mem_ready     = cpu_mem_ready;
            mem_data_read = cpu_mem_data_read;
            mem_resp      = cpu_mem_resp;
        end
    end

endmodule

// ==== design/clint.sv ====
`timescale 1ns/100ps
`include "clint_consts.svh"

module clint (
    input  logic                    inst_selfdefine,
    input  logic                    reset,
    input  logic                    clint_valid,
    input  logic [`CLINT_OFF_W-1:0] clint_addr,
    input  clint_pkg::size_t        clint_size,
    input  logic                    clint_req,
    input  clint_pkg::data_t        clint_data_write,
    output logic                    clint_ready,
    output clint_pkg::data_t        clint_data_read,
    output clint_pkg::resp_t        clint_resp,
    output logic                    mtip
);
    import clint_pkg::*;

    localparam int TICK_W = (`CLINT_TICK_DIV > 1) ? $clog2(`CLINT_TICK_DIV) : 1;

    logic [TICK_W-1:0] tick_cnt;
    logic              tick;
    data_t             mtime;
    data_t             mtimecmp;
    logic              accept;
    logic              hit_mtime;
    logic              hit_mtimecmp;
    logic              wr_mtime;
    logic              wr_mtimecmp;

    // new request, not the tail of the one just answered
    assign accept = clint_valid & ~clint_ready;

    // only doubleword accesses hit a register
    assign hit_mtime    = (clint_size == `SIZE_DOUBLE) && (clint_addr == `CLINT_MTIME_OFF);
    assign hit_mtimecmp = (clint_size == `SIZE_DOUBLE) && (clint_addr == `CLINT_MTIMECMP_OFF);

    assign wr_mtime    = accept & clint_req & hit_mtime;
    assign wr_mtimecmp = accept & clint_req & hit_mtimecmp;

    // prescaler
    assign tick = (tick_cnt == TICK_W'(`CLINT_TICK_DIV - 1));

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            tick_cnt <= '0;
        end else if (tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + TICK_W'(1);
        end
    end

    // software write wins over the tick
    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            mtime <= '0;
        end else if (wr_mtime) begin
            mtime <= clint_data_write;
        end else if (tick) begin
            mtime <= mtime + data_t'(1);
        end
    end

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            mtimecmp <= '1;
        end else if (wr_mtimecmp) begin
            mtimecmp <= clint_data_write;
        end
    end

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            mtip <= 1'b0;
        end else begin
            mtip <= (mtime >= mtimecmp);
        end
    end

    // one-cycle ready
    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            clint_ready <= 1'b0;
        end else begin
            clint_ready <= accept;
        end
    end

    // response payload, captured with the request
    always_ff @(posedge inst_selfdefine) begin
        if (accept) begin
            if (hit_mtime) begin
                clint_data_read <= clint_req ? '0 : mtime;
                clint_resp      <= `RESP_OKAY;
            end else if (hit_mtimecmp) begin
                clint_data_read <= clint_req ? '0 : mtimecmp;
                clint_resp      <= `RESP_OKAY;
            end else begin
                clint_data_read <= '0;
                clint_resp      <= `RESP_SLVERR;
            end
        end
    end

endmodule

// ==== design/soc_mem_top.sv ====
`timescale 1ns/100ps
`include "clint_consts.svh"

module soc_mem_top (
    input  logic             inst_selfdefine,
    input  logic             reset,

    // master port, driven by the core side
    input  logic             mem_valid,
    input  clint_pkg::addr_t mem_addr,
    input  clint_pkg::size_t mem_size,
    input  logic             mem_req,
    input  clint_pkg::data_t mem_data_write,
    output logic             mem_ready,
    output clint_pkg::data_t mem_data_read,
    output clint_pkg::resp_t mem_resp,

    // external memory port
    output logic             cpu_mem_valid,
    output clint_pkg::addr_t cpu_mem_addr,
    output clint_pkg::size_t cpu_mem_size,
    output logic             cpu_mem_req,
    output clint_pkg::data_t cpu_mem_data_write,
    input  logic             cpu_mem_ready,
    input  clint_pkg::data_t cpu_mem_data_read,
    input  clint_pkg::resp_t cpu_mem_resp,

    output logic             mtip
);
    import clint_pkg::*;

    logic                    clint_valid;
    logic [`CLINT_OFF_W-1:0] clint_addr;
    size_t                   clint_size;
    logic                    clint_req;
    data_t                   clint_data_write;
    logic                    clint_ready;
    data_t                   clint_data_read;
    resp_t                   clint_resp;

    mem_dstb u_mem_dstb (
        .mem_valid          (mem_valid),
        .mem_addr           (mem_addr),
        .mem_size           (mem_size),
        .mem_req            (mem_req),
        .mem_data_write     (mem_data_write),
        .mem_ready          (mem_ready),
        .mem_data_read      (mem_data_read),
        .mem_resp           (mem_resp),
        .cpu_mem_valid      (cpu_mem_valid),
        .cpu_mem_addr       (cpu_mem_addr),
        .cpu_mem_size       (cpu_mem_size),
        .cpu_mem_req        (cpu_mem_req),
        .cpu_mem_data_write (cpu_mem_data_write),
        .cpu_mem_ready      (cpu_mem_ready),
        .cpu_mem_data_read  (cpu_mem_data_read),
        .cpu_mem_resp       (cpu_mem_resp),
        .clint_valid        (clint_valid),
        .clint_addr         (clint_addr),
        .clint_size         (clint_size),
        .clint_req          (clint_req),
        .clint_data_write   (clint_data_write),
        .clint_ready        (clint_ready),
        .clint_data_read    (clint_data_read),
        .clint_resp         (clint_resp)
    );

    clint u_clint (
        .inst_selfdefine    (inst_selfdefine),
        .reset              (reset),
        .clint_valid        (clint_valid),
        .clint_addr         (clint_addr),
        .clint_size         (clint_size),
        .clint_req          (clint_req),
        .clint_data_write   (clint_data_write),
        .clint_ready        (clint_ready),
        .clint_data_read    (clint_data_read),
        .clint_resp         (clint_resp),
        .mtip               (mtip)
    );

endmodule

// ==== verif/soc_mem_asserts.sv ====
`timescale 1ns/100ps

module soc_mem_asserts (
    input logic             inst_selfdefine,
    input logic             reset,
    input logic             mem_valid,
    input clint_pkg::addr_t mem_addr,
    input clint_pkg::size_t mem_size,
    input logic             mem_req,
    input clint_pkg::data_t mem_data_write,
    input logic             mem_ready,
    input logic             cpu_mem_valid,
    input logic             clint_valid,
    input logic             clint_ready
);

    // one target per request
    one_target: assert property (@(posedge inst_selfdefine) disable iff (reset)
        !(cpu_mem_valid && clint_valid))
        else $error("cpu_mem_valid and clint_valid are high in the same cycle");

    // requester holds its fields until ready
    master_hold: assert property (@(posedge inst_selfdefine) disable iff (reset)
        (mem_valid && !mem_ready) |=>
            (mem_valid && $stable(mem_addr) && $stable(mem_size)
             && $stable(mem_req) && $stable(mem_data_write)))
        else $error("master request changed or dropped before mem_ready");

    // clint only answers a request seen one cycle earlier
    clint_ready_cause: assert property (@(posedge inst_selfdefine) disable iff (reset)
        clint_ready |-> $past(clint_valid))
        else $error("clint_ready high without clint_valid in the previous cycle");

endmodule

bind soc_mem_top soc_mem_asserts u_soc_mem_asserts (
    .inst_selfdefine (inst_selfdefine),
    .reset           (reset),
    .mem_valid       (mem_valid),
    .mem_addr        (mem_addr),
    .mem_size        (mem_size),
    .mem_req         (mem_req),
    .mem_data_write  (mem_data_write),
    .mem_ready       (mem_ready),
    .cpu_mem_valid   (cpu_mem_valid),
    .clint_valid     (clint_valid),
    .clint_ready     (clint_ready)
);

// ==== verif/tb_soc_mem.sv ====
`timescale 1ns/100ps
`include "clint_consts.svh"

module tb_soc_mem;
    import clint_pkg::*;

    // well above the combined length of all tests
    localparam int    WATCHDOG_CYCLES = 3000;
    localparam int    HS_LIMIT        = 20;
    localparam size_t SIZE_WORD       = 2'd2;
    localparam addr_t MTIME_ADDR      = `CLINT_BASE + addr_t'(`CLINT_MTIME_OFF);
    localparam addr_t MTIMECMP_ADDR   = `CLINT_BASE + addr_t'(`CLINT_MTIMECMP_OFF);
    localparam addr_t EXT_BASE        = 64'h0000_0000_8000_0040;

    logic  inst_selfdefine = 1'b0;
    logic  reset;
    logic  mem_valid;
    addr_t mem_addr;
    size_t mem_size;
    logic  mem_req;
    data_t mem_data_write;
    logic  mem_ready;
    data_t mem_data_read;
    resp_t mem_resp;
    logic  cpu_mem_valid;
    addr_t cpu_mem_addr;
    size_t cpu_mem_size;
    logic  cpu_mem_req;
    data_t cpu_mem_data_write;
    logic  cpu_mem_ready;
    data_t cpu_mem_data_read;
    resp_t cpu_mem_resp;
    logic  mtip;

    integer seed             = 32'h2bf73ee9;
    int     errors           = 0;
    int     checks           = 0;
    int     last_wait        = 0;
    int     ext_count        = 0;
    int     ext_valid_cycles = 0;

    // external memory model and the last request it took
    data_t  ext_mem [0:63];
    addr_t  cap_addr;
    size_t  cap_size;
    logic   cap_req;
    data_t  cap_wdata;
    logic   cap_clint_valid;

    soc_mem_top DUT (.*);

    always #20 inst_selfdefine = ~inst_selfdefine;

    always @(posedge inst_selfdefine) begin
        if (cpu_mem_valid) begin
            ext_valid_cycles <= ext_valid_cycles + 1;
        end
    end

    // external memory, random latency, always okay
    initial begin
        int delay;
        for (int i = 0; i < 64; i++) begin
            ext_mem[i[5:0]] = 64'hC0DE_0000_0000_0000 | data_t'(i * 8);
        end
        cpu_mem_ready     = 1'b0;
        cpu_mem_data_read = '0;
        cpu_mem_resp      = `RESP_OKAY;
        forever begin
            @(negedge inst_selfdefine);
            if (!reset && cpu_mem_valid) begin
                cap_addr        = cpu_mem_addr;
                cap_size        = cpu_mem_size;
                cap_req         = cpu_mem_req;
                cap_wdata       = cpu_mem_data_write;
                cap_clint_valid = DUT.clint_valid;
                ext_count++;
                delay = $unsigned($random(seed)) % 6;
                repeat (delay) @(posedge inst_selfdefine);
                @(posedge inst_selfdefine);
                #1;
                if (cap_req) begin
                    ext_mem[cap_addr[8:3]] = cap_wdata;
                end else begin
                    cpu_mem_data_read = ext_mem[cap_addr[8:3]];
                end
                cpu_mem_ready = 1'b1;
                @(posedge inst_selfdefine);
                #1;
                cpu_mem_ready     = 1'b0;
                cpu_mem_data_read = '0;
            end
        end
    end

    task automatic next_cycle();
        @(posedge inst_selfdefine);
        #1;
    endtask

    task automatic check_val(input string name, input data_t exp, input data_t got);
        checks++;
        assert (got === exp) else begin
            $display("ERROR %s: expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_range(input string name, input data_t lo, input data_t hi,
                               input data_t got);
        checks++;
        assert (got >= lo && got <= hi) else begin
            $display("ERROR %s: expected %h to %h, got %h", name, lo, hi, got);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("check failed: %s", what);
            errors++;
        end
    endtask

    // one master transaction, starts and ends 1 ns after a rising edge
    task automatic access(input logic wr, input addr_t addr, input size_t size,
                          input data_t wdata, output data_t rdata, output resp_t resp);
        bit done;
        done           = 1'b0;
        last_wait      = 0;
        rdata          = '0;
        resp           = '0;
        mem_valid      = 1'b1;
        mem_addr       = addr;
        mem_size       = size;
        mem_req        = wr;
        mem_data_write = wdata;
        while (!done && last_wait < HS_LIMIT) begin
            @(negedge inst_selfdefine);
            if (mem_ready) begin
                done  = 1'b1;
                rdata = mem_data_read;
                resp  = mem_resp;
            end else begin
                last_wait++;
            end
        end
        check_true(done, $sformatf("handshake at address %h never completed", addr));
        next_cycle();
        mem_valid = 1'b0;
        mem_req   = 1'b0;
    endtask

    task automatic clint_write(input addr_t addr, input data_t wdata);
        data_t rd;
        resp_t resp;
        access(1'b1, addr, `SIZE_DOUBLE, wdata, rd, resp);
        check_val("mem_resp", data_t'(`RESP_OKAY), data_t'(resp));
        check_val("mem_ready latency", 64'd1, data_t'(last_wait));
    endtask

    task automatic clint_read(input addr_t addr, output data_t rdata);
        resp_t resp;
        access(1'b0, addr, `SIZE_DOUBLE, '0, rdata, resp);
        check_val("mem_resp", data_t'(`RESP_OKAY), data_t'(resp));
        check_val("mem_ready latency", 64'd1, data_t'(last_wait));
    endtask

    task automatic expect_slverr(input logic wr, input addr_t addr, input size_t size);
        data_t rd;
        resp_t resp;
        access(wr, addr, size, 64'h5A5A_5A5A_5A5A_5A5A, rd, resp);
        check_val("mem_resp", data_t'(`RESP_SLVERR), data_t'(resp));
        check_val("mem_data_read", 64'd0, rd);
    endtask

    task automatic test_reset();
        data_t rd;
        @(negedge inst_selfdefine);
        check_val("mem_ready", 64'd0, data_t'(mem_ready));
        check_val("cpu_mem_valid", 64'd0, data_t'(cpu_mem_valid));
        check_val("mtip", 64'd0, data_t'(mtip));
        next_cycle();
        clint_read(MTIME_ADDR, rd);
        check_range("mtime", 64'd0, 64'd3, rd);
    endtask

    // includes both edges just outside the clint window
    task automatic test_external();
        addr_t addrs [10];
        data_t wdata [10];
        data_t rd;
        resp_t resp;
        int    count0;
        for (int i = 0; i < 8; i++) begin
            addrs[i] = EXT_BASE + addr_t'(i * 8);
        end
        addrs[8] = `CLINT_BASE - 64'd8;
        addrs[9] = `CLINT_BASE + `CLINT_SPAN;
        for (int k = 0; k < 20; k++) begin
            int i;
            i      = k % 10;
            count0 = ext_count;
            if (k < 10) begin
                wdata[i] = {$random(seed), $random(seed)};
                access(1'b1, addrs[i], `SIZE_DOUBLE, wdata[i], rd, resp);
                check_val("cpu_mem_data_write", wdata[i], cap_wdata);
            end else begin
                access(1'b0, addrs[i], `SIZE_DOUBLE, '0, rd, resp);
                check_val("mem_data_read", wdata[i], rd);
            end
            check_val("mem_resp", data_t'(`RESP_OKAY), data_t'(resp));
            check_val("cpu_mem_valid requests", data_t'(count0 + 1), data_t'(ext_count));
            check_val("cpu_mem_addr", addrs[i], cap_addr);
            check_val("cpu_mem_size", data_t'(`SIZE_DOUBLE), data_t'(cap_size));
            check_val("cpu_mem_req", data_t'(k < 10), data_t'(cap_req));
            check_val("clint_valid", 64'd0, data_t'(cap_clint_valid));
        end
    endtask

    task automatic test_mtimecmp();
        data_t rd;
        int    cycles0;
        cycles0 = ext_valid_cycles;
        clint_write(MTIMECMP_ADDR, 64'h0123_4567_89AB_CDEF);
        clint_read(MTIMECMP_ADDR, rd);
        check_val("mtimecmp", 64'h0123_4567_89AB_CDEF, rd);
        check_val("cpu_mem_valid cycles", data_t'(cycles0), data_t'(ext_valid_cycles));
    endtask

    task automatic test_timer();
        data_t rd;
        int    n;
        for (int k = 0; k < 2; k++) begin
            n = (k == 0) ? 40 : 100;
            clint_write(MTIME_ADDR, 64'd0);
            repeat (n) next_cycle();
            clint_read(MTIME_ADDR, rd);
            check_range("mtime", data_t'(n / `CLINT_TICK_DIV - 1),
                        data_t'(n / `CLINT_TICK_DIV + 2), rd);
        end
    endtask

    task automatic test_interrupt();
        int cycles;
        clint_write(MTIMECMP_ADDR, '1);
        clint_write(MTIME_ADDR, 64'd0);
        clint_write(MTIMECMP_ADDR, 64'd10);
        @(negedge inst_selfdefine);
        check_val("mtip", 64'd0, data_t'(mtip));
        cycles = 0;
        while (!mtip && cycles < 10 * `CLINT_TICK_DIV + 4) begin
            @(negedge inst_selfdefine);
            cycles++;
        end
        check_true(mtip === 1'b1, $sformatf("mtip did not rise within %0d cycles", cycles));
        check_true(cycles >= 7 * `CLINT_TICK_DIV, "mtip rose before mtime reached mtimecmp");
        next_cycle();
        clint_write(MTIMECMP_ADDR, '1);
        cycles = 0;
        do begin
            @(negedge inst_selfdefine);
            cycles++;
        end while (mtip && cycles < 2);
        check_val("mtip", 64'd0, data_t'(mtip));
        next_cycle();
    endtask

    task automatic test_errors();
        data_t rd;
        clint_write(MTIMECMP_ADDR, 64'hFEED_0000_1234_5678);
        expect_slverr(1'b0, MTIME_ADDR, SIZE_WORD);
        expect_slverr(1'b1, MTIMECMP_ADDR, SIZE_WORD);
        expect_slverr(1'b1, `CLINT_BASE + 64'h8, `SIZE_DOUBLE);
        expect_slverr(1'b0, `CLINT_BASE + 64'h4008, `SIZE_DOUBLE);
        clint_read(MTIMECMP_ADDR, rd);
        check_val("mtimecmp", 64'hFEED_0000_1234_5678, rd);
    endtask

    initial begin
        reset          = 1'b1;
        mem_valid      = 1'b0;
        mem_addr       = '0;
        mem_size       = '0;
        mem_req        = 1'b0;
        mem_data_write = '0;
        repeat (3) next_cycle();
        reset = 1'b0;
        test_reset();
        test_external();
        test_mtimecmp();
        test_timer();
        test_interrupt();
        test_errors();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge inst_selfdefine);
        $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
        $display("checks %0d, errors %0d", checks, errors);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== soc_mem.f ====
+incdir+include
design/clint_pkg.sv
design/mem_dstb.sv
design/clint.sv
design/soc_mem_top.sv
verif/soc_mem_asserts.sv
verif/tb_soc_mem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_soc_mem
RTL_TOP   ?= soc_mem_top
FILELIST  ?= soc_mem.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only
RTL_SRCS  ?= design/clint_pkg.sv design/mem_dstb.sv design/clint.sv design/soc_mem_top.sv
SRCS      := $(wildcard include/*.svh design/*.sv verif/*.sv) $(FILELIST)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	elif ! grep -q "sim passed" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) +incdir+include $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
